//--- Makefile
SIM := obj_dir/Vtb_lsu

all: run

$(SIM): lsu_unit.f $(wildcard rtl/*.sv verification/*.sv)
	verilator --binary --timing --assert --top-module tb_lsu -f lsu_unit.f -o Vtb_lsu

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- lsu_unit.f
rtl/lsu_pkg.sv
rtl/lsu_write_port.sv
rtl/lsu_read_port.sv
rtl/lsu_order_ctrl.sv
rtl/lsu_top.sv
verification/axil_mem_model.sv
verification/tb_lsu.sv

//--- rtl/lsu_order_ctrl.sv
// order controller: request acceptance, busy and flush tracking, writeback merge.
`timescale 1ns/1ps

module lsu_order_ctrl (
	input  logic                     CLK,
	input  logic                     rst,
	input  logic                     req_valid,
	input  lsu_pkg::lsu_req_t        req,
	output logic                     req_ready,
	input  logic                     flush,

	output logic                     wr_start,
	output logic                     rd_start,
	output logic [lsu_pkg::xlen-1:0] addr,
	output logic [lsu_pkg::xlen-1:0] wdata,
	output logic [1:0]               size,
	output lsu_pkg::load_kind_t      kind,

	input  logic                     wr_done,
	input  logic                     rd_done,
	input  logic [lsu_pkg::xlen-1:0] rd_data,

	output logic                     wb_valid,
	output lsu_pkg::lsu_wb_t         wb
);

	logic                     is_load;
	logic                     is_store;
	logic [1:0]               dec_size;
	logic                     dec_unsigned;
	logic                     issue;
	logic                     done_any;
	logic                     busy;
	logic                     invalid;     // result of the op in flight is dropped.
	logic                     fence_done;
	logic                     load_q;
	logic [lsu_pkg::rd_w-1:0] rd_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		is_load      = 1'b0;
		is_store     = 1'b0;
		dec_size     = lsu_pkg::sz_dbl;
		dec_unsigned = 1'b0;
		case (req.op)
			lsu_pkg::op_lb:  begin is_load = 1'b1; dec_size = lsu_pkg::sz_byte; end
			lsu_pkg::op_lh:  begin is_load = 1'b1; dec_size = lsu_pkg::sz_half; end
			lsu_pkg::op_lw:  begin is_load = 1'b1; dec_size = lsu_pkg::sz_word; end
			lsu_pkg::op_ld:  is_load = 1'b1;
			lsu_pkg::op_lbu: begin
				is_load      = 1'b1;
				dec_size     = lsu_pkg::sz_byte;
				dec_unsigned = 1'b1;
			end
			lsu_pkg::op_lhu: begin
				is_load      = 1'b1;
				dec_size     = lsu_pkg::sz_half;
				dec_unsigned = 1'b1;
			end
			lsu_pkg::op_lwu: begin
				is_load      = 1'b1;
				dec_size     = lsu_pkg::sz_word;
				dec_unsigned = 1'b1;
			end
			lsu_pkg::op_sb:  begin is_store = 1'b1; dec_size = lsu_pkg::sz_byte; end
			lsu_pkg::op_sh:  begin is_store = 1'b1; dec_size = lsu_pkg::sz_half; end
			lsu_pkg::op_sw:  begin is_store = 1'b1; dec_size = lsu_pkg::sz_word; end
			lsu_pkg::op_sd:  is_store = 1'b1;
			lsu_pkg::op_fence, lsu_pkg::op_fence_i: ;   // no bus traffic.
			default: ;                                   // unused codes act as fence.
		endcase
	end

	assign req_ready = ~busy;
	assign issue     = req_valid & req_ready & ~flush;
	assign done_any  = wr_done | rd_done | fence_done;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control state.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge CLK) begin
		if (rst) begin
			busy       <= 1'b0;
			invalid    <= 1'b0;
			wr_start   <= 1'b0;
			rd_start   <= 1'b0;
			fence_done <= 1'b0;
			wb_valid   <= 1'b0;
		end else begin
			wr_start   <= issue & is_store;
			rd_start   <= issue & is_load;
			fence_done <= issue & ~is_load & ~is_store;   // completes next cycle.
			wb_valid   <= done_any & ~invalid & ~flush;
			if (issue) busy <= 1'b1;
			else if (done_any) busy <= 1'b0;
			if (done_any) invalid <= 1'b0;
			else if (busy && flush) invalid <= 1'b1;
		end
	end

	// request and writeback payload.
	always_ff @(posedge CLK) begin
		if (issue) begin
			addr             <= req.addr;
			wdata            <= req.wdata;
			size             <= dec_size;
			kind.size        <= dec_size;
			kind.is_unsigned <= dec_unsigned;
			rd_q             <= req.rd;
			load_q           <= is_load;
		end
		if (done_any) begin
			wb.rd  <= rd_q;
			wb.res <= load_q ? rd_data : '0;   // stores and fences give zero.
		end
	end

	// a completion marked invalid never reaches the core.
	a_no_stale_wb: assert property (@(posedge CLK) disable iff (rst)
		wb_valid |-> !invalid);

endmodule

//--- rtl/lsu_pkg.sv
// widths, operation enum, size codes, and request, writeback and load shape structs.

package lsu_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int xlen = 64;          // data and address width.
	localparam int rb   = 2;           // rename bits.
	localparam int rd_w = 5 + rb;      // destination tag width.

	// access size codes, shared by stores and loads.
	localparam logic [1:0] sz_byte = 2'd0;
	localparam logic [1:0] sz_half = 2'd1;
	localparam logic [1:0] sz_word = 2'd2;
	localparam logic [1:0] sz_dbl  = 2'd3;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operations.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [3:0] {
		op_lb      = 4'd0,
		op_lh      = 4'd1,
		op_lw      = 4'd2,
		op_ld      = 4'd3,
		op_lbu     = 4'd4,
		op_lhu     = 4'd5,
		op_lwu     = 4'd6,
		op_sb      = 4'd7,
		op_sh      = 4'd8,
		op_sw      = 4'd9,
		op_sd      = 4'd10,
		op_fence   = 4'd11,
		op_fence_i = 4'd12
	} lsu_op_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// structs.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// one request from execute.
	typedef struct packed {
		lsu_op_e           op;
		logic [rd_w-1:0]   rd;     // destination tag.
		logic [xlen-1:0]   addr;
		logic [xlen-1:0]   wdata;  // store data, low lanes.
	} lsu_req_t;

	// writeback payload, valid travels beside it.
	typedef struct packed {
		logic [rd_w-1:0]   rd;
		logic [xlen-1:0]   res;
	} lsu_wb_t;

	// shape of a load result.
	typedef struct packed {
		logic [1:0]        size;
		logic              is_unsigned;
	} load_kind_t;

endpackage

//--- rtl/lsu_read_port.sv
// read port: AR and R channel sequencing for loads, with the captured and extended result.
`timescale 1ns/1ps

module lsu_read_port (
	input  logic                     CLK,
	input  logic                     rst,
	input  logic                     start,
	input  logic [lsu_pkg::xlen-1:0] addr,
	input  lsu_pkg::load_kind_t      kind,

	output logic [lsu_pkg::xlen-1:0] araddr,
	output logic                     arvalid,
	input  logic                     arready,

	input  logic [lsu_pkg::xlen-1:0] rdata,
	input  logic                     rvalid,
	output logic                     rready,

	output logic                     done,
	output logic [lsu_pkg::xlen-1:0] rd_data
);

	lsu_pkg::load_kind_t kind_q;
	logic                pending;
	logic                capture;

	// zero or sign extension from the low bits of the word.
	function automatic logic [lsu_pkg::xlen-1:0] extend(
		input lsu_pkg::load_kind_t      k,
		input logic [lsu_pkg::xlen-1:0] d
	);
		logic [lsu_pkg::xlen-1:0] r;
		case (k.size)
			lsu_pkg::sz_byte:
				r = k.is_unsigned ? {{(lsu_pkg::xlen-8){1'b0}}, d[7:0]}
				                  : {{(lsu_pkg::xlen-8){d[7]}}, d[7:0]};
			lsu_pkg::sz_half:
				r = k.is_unsigned ? {{(lsu_pkg::xlen-16){1'b0}}, d[15:0]}
				                  : {{(lsu_pkg::xlen-16){d[15]}}, d[15:0]};
			lsu_pkg::sz_word:
				r = k.is_unsigned ? {{(lsu_pkg::xlen-32){1'b0}}, d[31:0]}
				                  : {{(lsu_pkg::xlen-32){d[31]}}, d[31:0]};
			default:
				r = d;   // double, whole word.
		endcase
		return r;
	endfunction

	// first cycle rvalid is seen for this load.
	assign capture = rvalid & ~rready & pending;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// channel control.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge CLK) begin
		if (rst) begin
			pending <= 1'b0;
			arvalid <= 1'b0;
			rready  <= 1'b0;
		end else begin
			if (start) begin
				pending <= 1'b1;
				arvalid <= 1'b1;
			end else begin
				if (arvalid && arready) arvalid <= 1'b0;
				if (rready) pending <= 1'b0;
			end
			rready <= capture;
		end
	end

	// payload.
	always_ff @(posedge CLK) begin
		if (start) begin
			araddr <= addr;
			kind_q <= kind;
		end
		if (capture) rd_data <= extend(kind_q, rdata);
	end

	assign done = rready;   // result valid in this cycle.

	a_ar_hold: assert property (@(posedge CLK) disable iff (rst)
		arvalid && !arready |=> arvalid);

endmodule

//--- rtl/lsu_top.sv
// load/store unit top: order controller, write port and read port on AXI-Lite.
`timescale 1ns/1ps

module lsu_top (
	input  logic                     CLK,
	input  logic                     rst,

	// execute side.
	input  logic                     req_valid,
	input  lsu_pkg::lsu_req_t        req,
	output logic                     req_ready,
	input  logic                     flush,
	output logic                     wb_valid,
	output lsu_pkg::lsu_wb_t         wb,

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// AXI-Lite master.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	output logic [lsu_pkg::xlen-1:0] awaddr,
	output logic [2:0]               awprot,
	output logic                     awvalid,
	input  logic                     awready,

	output logic [lsu_pkg::xlen-1:0] wdata,
	output logic [7:0]               wstrb,
	output logic                     wvalid,
	input  logic                     wready,

	input  logic                     bvalid,
	output logic                     bready,

	output logic [lsu_pkg::xlen-1:0] araddr,
	output logic [2:0]               arprot,
	output logic                     arvalid,
	input  logic                     arready,

	input  logic [lsu_pkg::xlen-1:0] rdata,
	input  logic                     rvalid,
	output logic                     rready
);

	logic                     wr_start;
	logic                     rd_start;
	logic                     wr_done;
	logic                     rd_done;
	logic [lsu_pkg::xlen-1:0] op_addr;
	logic [lsu_pkg::xlen-1:0] op_wdata;
	logic [1:0]               op_size;
	lsu_pkg::load_kind_t      op_kind;
	logic [lsu_pkg::xlen-1:0] ld_data;

	assign awprot = 3'b000;
	assign arprot = 3'b001;   // privileged data access.

	lsu_order_ctrl u_ctrl (
		.CLK       (CLK),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.flush     (flush),
		.wr_start  (wr_start),
		.rd_start  (rd_start),
		.addr      (op_addr),
		.wdata     (op_wdata),
		.size      (op_size),
		.kind      (op_kind),
		.wr_done   (wr_done),
		.rd_done   (rd_done),
		.rd_data   (ld_data),
		.wb_valid  (wb_valid),
		.wb        (wb)
	);

	lsu_write_port u_wr (
		.CLK     (CLK),
		.rst     (rst),
		.start   (wr_start),
		.addr    (op_addr),
		.wdata   (op_wdata),
		.size    (op_size),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata_o (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bvalid  (bvalid),
		.bready  (bready),
		.done    (wr_done)
	);

	lsu_read_port u_rd (
		.CLK     (CLK),
		.rst     (rst),
		.start   (rd_start),
		.addr    (op_addr),
		.kind    (op_kind),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rvalid  (rvalid),
		.rready  (rready),
		.done    (rd_done),
		.rd_data (ld_data)
	);

endmodule

//--- rtl/lsu_write_port.sv
// write port: AW, W and B channel sequencing for stores, with strobe generation.
`timescale 1ns/1ps

module lsu_write_port (
	input  logic                     CLK,
	input  logic                     rst,
	input  logic                     start,
	input  logic [lsu_pkg::xlen-1:0] addr,
	input  logic [lsu_pkg::xlen-1:0] wdata,
	input  logic [1:0]               size,

	output logic [lsu_pkg::xlen-1:0] awaddr,
	output logic                     awvalid,
	input  logic                     awready,

	output logic [lsu_pkg::xlen-1:0] wdata_o,
	output logic [7:0]               wstrb,
	output logic                     wvalid,
	input  logic                     wready,

	input  logic                     bvalid,
	output logic                     bready,

	output logic                     done
);

	logic       pending;   // store issued, response not yet taken.
	logic [7:0] strb_mask;

	// low lanes only, no address shift.
	always_comb begin
		case (size)
			lsu_pkg::sz_byte: strb_mask = 8'h01;
			lsu_pkg::sz_half: strb_mask = 8'h03;
			lsu_pkg::sz_word: strb_mask = 8'h0f;
			default:          strb_mask = 8'hff;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// channel control.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge CLK) begin
		if (rst) begin
			pending <= 1'b0;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			bready  <= 1'b0;
		end else begin
			if (start) begin
				pending <= 1'b1;
				awvalid <= 1'b1;   // aw and w rise together.
				wvalid  <= 1'b1;
			end else begin
				if (awvalid && awready) awvalid <= 1'b0;
				if (wvalid && wready) wvalid <= 1'b0;
				if (bready) pending <= 1'b0;
			end
			bready <= bvalid & ~bready & pending;   // one cycle pulse.
		end
	end

	// payload, loaded on start only.
	always_ff @(posedge CLK) begin
		if (start) begin
			awaddr  <= addr;
			wdata_o <= wdata;
			wstrb   <= strb_mask;
		end
	end

	assign done = bready;

	// awvalid stays up until the slave takes it.
	a_aw_hold: assert property (@(posedge CLK) disable iff (rst)
		awvalid && !awready |=> awvalid);

	// the controller keeps one operation in flight.
	a_no_overlap: assert property (@(posedge CLK) disable iff (rst)
		start |-> !pending);

endmodule

//--- verification/axil_mem_model.sv
// AXI-Lite slave memory model with pseudo-random ready and valid delays.
`timescale 1ns/1ps

module axil_mem_model (
	input  logic                     CLK,
	input  logic                     rst,
	input  logic [lsu_pkg::xlen-1:0] awaddr,
	input  logic                     awvalid,
	output logic                     awready,
	input  logic [lsu_pkg::xlen-1:0] wdata,
	input  logic [7:0]               wstrb,
	input  logic                     wvalid,
	output logic                     wready,
	output logic                     bvalid,
	input  logic                     bready,
	input  logic [lsu_pkg::xlen-1:0] araddr,
	input  logic                     arvalid,
	output logic                     arready,
	output logic [lsu_pkg::xlen-1:0] rdata,
	output logic                     rvalid,
	input  logic                     rready
);

	logic [63:0] mem [logic [60:0]];   // word index is addr[63:3].
	logic [31:0] seed;
	logic [1:0]  aw_wait;
	logic [1:0]  w_wait;
	logic [1:0]  b_wait;
	logic [1:0]  ar_wait;
	logic [1:0]  r_wait;
	logic        aw_got;
	logic        w_got;
	logic        ar_got;
	logic [60:0] aw_idx;
	logic [60:0] ar_idx;
	logic [63:0] w_data;
	logic [7:0]  w_strb;
	logic [63:0] word;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// untouched words, spread over the whole index.
	function automatic logic [63:0] fill_word(input logic [60:0] idx);
		return {3'b000, idx} * 64'h9e37_79b9_7f4a_7c15;
	endfunction

	function automatic logic [63:0] read_word(input logic [60:0] idx);
		return mem.exists(idx) ? mem[idx] : fill_word(idx);
	endfunction

	always @(posedge CLK) begin
		if (rst) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			arready <= 1'b0;
			rvalid  <= 1'b0;
			aw_got  <= 1'b0;
			w_got   <= 1'b0;
			ar_got  <= 1'b0;
			aw_wait <= 2'd0;
			w_wait  <= 2'd0;
			b_wait  <= 2'd0;
			ar_wait <= 2'd0;
			r_wait  <= 2'd0;
			seed = 32'h2299;
		end else begin
			awready <= 1'b0;   // ready is a single pulse.
			wready  <= 1'b0;
			arready <= 1'b0;

			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// write side.
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			if (awvalid && !awready && !aw_got) begin
				if (aw_wait == 2'd0) awready <= 1'b1;
				else aw_wait <= aw_wait - 2'd1;
			end
			if (awvalid && awready) begin
				seed = lcg_next(seed);
				aw_got  <= 1'b1;
				aw_idx  <= awaddr[63:3];
				aw_wait <= seed[17:16];
			end
			if (wvalid && !wready && !w_got) begin
				if (w_wait == 2'd0) wready <= 1'b1;
				else w_wait <= w_wait - 2'd1;
			end
			if (wvalid && wready) begin
				seed = lcg_next(seed);
				w_got  <= 1'b1;
				w_data <= wdata;
				w_strb <= wstrb;
				w_wait <= seed[17:16];
			end
			// response once address and data are both in.
			if (aw_got && w_got && !bvalid) begin
				if (b_wait == 2'd0) begin
					word = read_word(aw_idx);
					for (int i = 0; i < 8; i++) begin
						if (w_strb[i]) word[8*i +: 8] = w_data[8*i +: 8];
					end
					mem[aw_idx] = word;
					bvalid <= 1'b1;
				end else begin
					b_wait <= b_wait - 2'd1;
				end
			end
			if (bvalid && bready) begin
				seed = lcg_next(seed);
				bvalid <= 1'b0;
				aw_got <= 1'b0;
				w_got  <= 1'b0;
				b_wait <= seed[17:16];
			end

			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// read side.
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			if (arvalid && !arready && !ar_got) begin
				if (ar_wait == 2'd0) arready <= 1'b1;
				else ar_wait <= ar_wait - 2'd1;
			end
			if (arvalid && arready) begin
				seed = lcg_next(seed);
				ar_got  <= 1'b1;
				ar_idx  <= araddr[63:3];
				ar_wait <= seed[17:16];
			end
			if (ar_got && !rvalid) begin
				if (r_wait == 2'd0) begin
					rdata  <= read_word(ar_idx);   // whole word.
					rvalid <= 1'b1;
				end else begin
					r_wait <= r_wait - 2'd1;
				end
			end
			if (rvalid && rready) begin
				seed = lcg_next(seed);
				rvalid <= 1'b0;
				ar_got <= 1'b0;
				r_wait <= seed[17:16];
			end
		end
	end

endmodule

//--- verification/tb_lsu.sv
// testbench for the load/store unit: clock, reset, directed tests, checks and summary.
`timescale 1ns/1ps

module tb_lsu;

	localparam int          half_period = 20;    // 40 ns clock.
	localparam int          wait_limit  = 200;   // cycles per wait loop.
	localparam logic [63:0] st_addr     = 64'h0000_0000_0000_1000;
	localparam logic [63:0] ld_addr     = 64'h0000_0000_0000_2008;
	localparam logic [63:0] ld_word     = 64'hf0e1_d2c3_b4a5_9687;
	localparam logic [63:0] chain_base  = 64'h0000_0000_0000_3000;

	logic                     CLK;
	logic                     rst;
	logic                     req_valid;
	lsu_pkg::lsu_req_t        req;
	logic                     req_ready;
	logic                     flush;
	logic                     wb_valid;
	lsu_pkg::lsu_wb_t         wb;
	logic [lsu_pkg::xlen-1:0] awaddr;
	logic [2:0]               awprot;
	logic                     awvalid;
	logic                     awready;
	logic [lsu_pkg::xlen-1:0] wdata;
	logic [7:0]               wstrb;
	logic                     wvalid;
	logic                     wready;
	logic                     bvalid;
	logic                     bready;
	logic [lsu_pkg::xlen-1:0] araddr;
	logic [2:0]               arprot;
	logic                     arvalid;
	logic                     arready;
	logic [lsu_pkg::xlen-1:0] rdata;
	logic                     rvalid;
	logic                     rready;

	int          pass_cnt;
	int          fail_cnt;
	int          errs;       // errors in the running test.
	logic [31:0] rng;

	lsu_top u_dut (
		.CLK       (CLK),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.flush     (flush),
		.wb_valid  (wb_valid),
		.wb        (wb),
		.awaddr    (awaddr),
		.awprot    (awprot),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arprot    (arprot),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rvalid    (rvalid),
		.rready    (rready)
	);

	axil_mem_model u_mem (
		.CLK     (CLK),
		.rst     (rst),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	initial begin
		CLK = 1'b0;
		forever #half_period CLK = ~CLK;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference rules.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// low lanes written by each store.
	function automatic logic [7:0] byte_mask(input lsu_pkg::lsu_op_e op);
		case (op)
			lsu_pkg::op_sb: return 8'h01;
			lsu_pkg::op_sh: return 8'h03;
			lsu_pkg::op_sw: return 8'h0f;
			default:        return 8'hff;
		endcase
	endfunction

	function automatic logic [63:0] merge(
		input logic [63:0] old,
		input logic [63:0] data,
		input logic [7:0]  mask
	);
		logic [63:0] r;
		r = old;
		for (int i = 0; i < 8; i++) begin
			if (mask[i]) r[8*i +: 8] = data[8*i +: 8];
		end
		return r;
	endfunction

	function automatic logic [63:0] extend_exp(input lsu_pkg::lsu_op_e op, input logic [63:0] w);
		case (op)
			lsu_pkg::op_lb:  return {{56{w[7]}}, w[7:0]};
			lsu_pkg::op_lh:  return {{48{w[15]}}, w[15:0]};
			lsu_pkg::op_lw:  return {{32{w[31]}}, w[31:0]};
			lsu_pkg::op_lbu: return {56'h0, w[7:0]};
			lsu_pkg::op_lhu: return {48'h0, w[15:0]};
			lsu_pkg::op_lwu: return {32'h0, w[31:0]};
			default:         return w;
		endcase
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// drive and check helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic step();
		@(posedge CLK);
		#2;   // inputs move just after the edge.
	endtask

	task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			errs++;
		end
	endtask

	task automatic finish_test(input string name);
		if (errs == 0) begin
			$display("PASS %s", name);
			pass_cnt++;
		end else begin
			$display("FAIL %s with %0d errors", name, errs);
			fail_cnt++;
		end
	endtask

	// one request through to its writeback.
	task automatic run_op(
		input  lsu_pkg::lsu_op_e         op,
		input  logic [lsu_pkg::rd_w-1:0] rd,
		input  logic [63:0]              addr,
		input  logic [63:0]              data,
		output logic [63:0]              res,
		output int                       cycles,
		output bit                       bus_seen
	);
		int n;
		bit early_ready;
		n = 0;
		early_ready = 1'b0;
		res = '0;
		cycles = 0;
		bus_seen = 1'b0;
		while (!req_ready && n < wait_limit) begin
			step();
			n++;
		end
		if (!req_ready) begin
			$display("timeout waiting for req_ready before a request");
			errs++;
		end
		req_valid  = 1'b1;
		req.op     = op;
		req.rd     = rd;
		req.addr   = addr;
		req.wdata  = data;
		step();   // accepted on this edge.
		req_valid = 1'b0;
		cycles = 1;   // counted from the acceptance cycle.
		while (!wb_valid && cycles < wait_limit) begin
			if (req_ready) early_ready = 1'b1;
			if (awvalid || wvalid || arvalid) bus_seen = 1'b1;
			if (awvalid) expect_eq("awprot", {61'h0, awprot}, 64'h0);
			if (arvalid) expect_eq("arprot", {61'h0, arprot}, 64'h1);
			step();
			cycles++;
		end
		if (awvalid || wvalid || arvalid) bus_seen = 1'b1;
		if (early_ready) begin
			$display("req_ready went high before the operation completed");
			errs++;
		end
		if (!wb_valid) begin
			$display("timeout waiting for wb_valid");
			errs++;
		end else begin
			expect_eq("wb.rd", {57'h0, wb.rd}, {57'h0, rd});
			res = wb.res;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic test_stores();
		logic [63:0] res;
		logic [63:0] exp;
		int          cycles;
		bit          bus_seen;
		errs = 0;
		exp = 64'h0011_2233_4455_6677;
		run_op(lsu_pkg::op_sd, 7'h01, st_addr, exp, res, cycles, bus_seen);
		expect_eq("wb.res", res, 64'h0);
		run_op(lsu_pkg::op_sb, 7'h02, st_addr, 64'hffff_ffff_ffff_ffab, res, cycles, bus_seen);
		expect_eq("wb.res", res, 64'h0);
		exp = merge(exp, 64'hffff_ffff_ffff_ffab, byte_mask(lsu_pkg::op_sb));
		run_op(lsu_pkg::op_sh, 7'h43, st_addr, 64'heeee_eeee_eeee_cd12, res, cycles, bus_seen);
		expect_eq("wb.res", res, 64'h0);
		exp = merge(exp, 64'heeee_eeee_eeee_cd12, byte_mask(lsu_pkg::op_sh));
		run_op(lsu_pkg::op_sw, 7'h7f, st_addr, 64'hdddd_dddd_89ab_0000, res, cycles, bus_seen);
		expect_eq("wb.res", res, 64'h0);
		exp = merge(exp, 64'hdddd_dddd_89ab_0000, byte_mask(lsu_pkg::op_sw));
		run_op(lsu_pkg::op_ld, 7'h05, st_addr, 64'h0, res, cycles, bus_seen);
		expect_eq("wb.res", res, exp);
		finish_test("stores of each size");
	endtask

	task automatic test_loads();
		logic [63:0]      res;
		lsu_pkg::lsu_op_e op;
		int               cycles;
		bit               bus_seen;
		errs = 0;
		run_op(lsu_pkg::op_sd, 7'h06, ld_addr, ld_word, res, cycles, bus_seen);
		op = lsu_pkg::op_lb;
		repeat (7) begin   // lb through lwu.
			run_op(op, 7'h10, ld_addr, 64'h0, res, cycles, bus_seen);
			expect_eq("wb.res", res, extend_exp(op, ld_word));
			op = op.next();
		end
		finish_test("loads of each width");
	endtask

	task automatic test_fence();
		logic [63:0] res;
		int          cycles;
		bit          bus_seen;
		errs = 0;
		run_op(lsu_pkg::op_fence, 7'h2a, 64'h0, 64'h0, res, cycles, bus_seen);
		expect_eq("wb_valid latency", 64'(cycles), 64'd2);
		expect_eq("wb.res", res, 64'h0);
		if (bus_seen) begin
			$display("fence raised an AXI valid");
			errs++;
		end
		finish_test("fence");
	endtask

	task automatic test_flush();
		logic [63:0] res;
		int          cycles;
		bit          bus_seen;
		int          n;
		bit          wb_seen;
		errs = 0;
		n = 0;
		wb_seen = 1'b0;
		req_valid = 1'b1;
		req.op    = lsu_pkg::op_ld;
		req.rd    = 7'h11;
		req.addr  = ld_addr;
		req.wdata = 64'h0;
		step();
		req_valid = 1'b0;
		flush = 1'b1;   // load now pending on the bus.
		step();
		flush = 1'b0;
		while (!req_ready && n < wait_limit) begin
			if (wb_valid) wb_seen = 1'b1;
			step();
			n++;
		end
		if (wb_valid) wb_seen = 1'b1;
		if (!req_ready) begin
			$display("timeout waiting for req_ready after flush");
			errs++;
		end
		if (wb_seen) begin
			$display("flushed load produced a writeback");
			errs++;
		end
		run_op(lsu_pkg::op_ld, 7'h12, ld_addr, 64'h0, res, cycles, bus_seen);
		expect_eq("wb.res", res, ld_word);
		finish_test("flush");
	endtask

	task automatic test_chain();
		logic [63:0]      shadow [4];   // expected memory words.
		logic [63:0]      res;
		logic [63:0]      data;
		logic [63:0]      addr;
		logic [3:0]       sel;
		logic [1:0]       slot;
		lsu_pkg::lsu_op_e op;
		int               cycles;
		bit               bus_seen;
		errs = 0;
		for (int k = 0; k < 4; k++) begin
			rng = lcg_next(rng);
			data = {rng, ~rng};
			slot = k[1:0];
			shadow[slot] = data;
			addr = chain_base | {59'h0, slot, 3'b000};
			run_op(lsu_pkg::op_sd, 7'h20, addr, data, res, cycles, bus_seen);
		end
		repeat (20) begin
			rng = lcg_next(rng);
			sel = rng[19:16];
			if (sel > 4'd10) sel = sel - 4'd5;
			op = lsu_pkg::lsu_op_e'(sel);
			slot = rng[21:20];
			addr = chain_base | {59'h0, slot, 3'b000};
			data[63:32] = rng;
			rng = lcg_next(rng);
			data[31:0] = rng;
			run_op(op, rng[28:22], addr, data, res, cycles, bus_seen);
			if (op >= lsu_pkg::op_sb) begin
				shadow[slot] = merge(shadow[slot], data, byte_mask(op));
				expect_eq("wb.res", res, 64'h0);
			end else begin
				expect_eq("wb.res", res, extend_exp(op, shadow[slot]));
			end
		end
		finish_test("random chain with ready tracking");
	endtask

	initial begin
		rst       = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		flush     = 1'b0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		errs      = 0;
		rng       = 32'h2299;
		repeat (8) @(posedge CLK);
		#2;
		rst = 1'b0;
		step();
		test_stores();
		test_loads();
		test_fence();
		test_flush();
		test_chain();
		$display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
